//--- compile.f
rv_pkg.sv
rv_regfile.sv
rv_idu_decoder.sv
rv_idu.sv
rv_exu.sv
rv_wbu.sv
rv_core.sv
tb_rv_core.sv

//--- rv_core.sv
`timescale 1ns/1ps

module rv_core
  import rv_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    fetch_valid_i,
  input  fetch_s  fetch_i,
  output logic    fetch_ready_o,
  output logic    retire_valid_o,
  output retire_s retire_o,
  input  logic    retire_ready_i
);

  logic                         idu_valid;
  exu_req_s                     idu_req;
  logic                         exu_ready;
  logic                         exu_valid;
  wb_req_s                      exu_wb;
  logic                         wbu_ready;
  fwd_s                         fwd;
  logic [reg_addr_w_p-1:0]      rs1;
  logic [reg_addr_w_p-1:0]      rs2;
  logic [xlen_p-1:0]            rdata1;
  logic [xlen_p-1:0]            rdata2;
  logic [(1<<reg_addr_w_p)-1:0] busy;
  logic                         set_en;
  logic [reg_addr_w_p-1:0]      set_rd;
  logic                         rf_wen;
  logic [reg_addr_w_p-1:0]      rf_wrd;
  logic [xlen_p-1:0]            rf_wdata;

  rv_idu rv_idu_inst (
    .clk           (clk),
    .rst           (rst),
    .fetch_valid_i (fetch_valid_i),
    .fetch_i       (fetch_i),
    .fetch_ready_o (fetch_ready_o),
    .rs1_o         (rs1),
    .rs2_o         (rs2),
    .rdata1_i      (rdata1),
    .rdata2_i      (rdata2),
    .busy_i        (busy),
    .fwd_i         (fwd),
    .set_en_o      (set_en),
    .set_rd_o      (set_rd),
    .valid_o       (idu_valid),
    .req_o         (idu_req),
    .ready_i       (exu_ready)
  );

  rv_exu rv_exu_inst (
    .clk     (clk),
    .rst     (rst),
    .valid_i (idu_valid),
    .req_i   (idu_req),
    .ready_o (exu_ready),
    .fwd_o   (fwd),
    .valid_o (exu_valid),
    .wb_o    (exu_wb),
    .ready_i (wbu_ready)
  );

  rv_wbu rv_wbu_inst (
    .clk            (clk),
    .rst            (rst),
    .valid_i        (exu_valid),
    .wb_i           (exu_wb),
    .ready_o        (wbu_ready),
    .wen_o          (rf_wen),
    .wrd_o          (rf_wrd),
    .wdata_o        (rf_wdata),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o),
    .retire_ready_i (retire_ready_i)
  );

  rv_regfile rv_regfile_inst (
    .clk      (clk),
    .rst      (rst),
    .rs1_i    (rs1),
    .rs2_i    (rs2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2),
    .busy_o   (busy),
    .set_en_i (set_en),
    .set_rd_i (set_rd),
    .wen_i    (rf_wen),
    .wrd_i    (rf_wrd),
    .wdata_i  (rf_wdata)
  );

endmodule

//--- rv_exu.sv
`timescale 1ns/1ps

module rv_exu
  import rv_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     valid_i,
  input  exu_req_s req_i,
  output logic     ready_o,
  output fwd_s     fwd_o,
  output logic     valid_o,
  output wb_req_s  wb_o,
  input  logic     ready_i
);

  exu_req_s          req;
  logic              valid;
  logic [4:0]        shamt;
  logic [xlen_p-1:0] alu_res;
  logic [xlen_p-1:0] link;
  logic [xlen_p-1:0] target;
  logic [xlen_p-1:0] wdata;

  assign ready_o = !valid || ready_i;
  assign valid_o = valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
    end else if (ready_o) begin
      valid <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i && ready_o) begin
      req <= req_i;
    end
  end

  assign shamt = req.op2[4:0];

  always_comb begin
    case (req.alu_op)
      alu_add:    alu_res = req.op1 + req.op2;
      alu_sub:    alu_res = req.op1 - req.op2;
      alu_sll:    alu_res = req.op1 << shamt;
      alu_slt:    alu_res = {31'b0, $signed(req.op1) < $signed(req.op2)};
      alu_sltu:   alu_res = {31'b0, req.op1 < req.op2};
      alu_xor:    alu_res = req.op1 ^ req.op2;
      alu_srl:    alu_res = req.op1 >> shamt;
      alu_sra:    alu_res = $signed(req.op1) >>> shamt;
      alu_or:     alu_res = req.op1 | req.op2;
      alu_and:    alu_res = req.op1 & req.op2;
      default:    alu_res = req.op2;
    endcase
  end

  // jumps write the link and report the target with bit 0 cleared
  assign link   = req.pc + 32'd4;
  assign target = (req.opj + req.op2) & ~32'd1;
  assign wdata  = req.jen ? link : alu_res;

  assign wb_o.pc     = req.pc;
  assign wb_o.rd     = req.rd;
  assign wb_o.wdata  = wdata;
  assign wb_o.wen    = req.wen;
  assign wb_o.jen    = req.jen;
  assign wb_o.target = req.jen ? target : '0;

  assign fwd_o.valid = valid && req.wen;
  assign fwd_o.rd    = req.rd;
  assign fwd_o.data  = wdata;

endmodule

//--- rv_idu.sv
`timescale 1ns/1ps

module rv_idu
  import rv_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          fetch_valid_i,
  input  fetch_s                        fetch_i,
  output logic                          fetch_ready_o,
  output logic [reg_addr_w_p-1:0]       rs1_o,
  output logic [reg_addr_w_p-1:0]       rs2_o,
  input  logic [xlen_p-1:0]             rdata1_i,
  input  logic [xlen_p-1:0]             rdata2_i,
  input  logic [(1<<reg_addr_w_p)-1:0]  busy_i,
  input  fwd_s                          fwd_i,
  output logic                          set_en_o,
  output logic [reg_addr_w_p-1:0]       set_rd_o,
  output logic                          valid_o,
  output exu_req_s                      req_o,
  input  logic                          ready_i
);

  fetch_s            held;
  logic              valid;
  logic [6:0]        opcode;
  logic              rs1_fwd;
  logic              rs2_fwd;
  logic [xlen_p-1:0] rs1_val;
  logic [xlen_p-1:0] rs2_val;
  logic              no_read;
  logic              uses_rs2;
  logic              raw_hazard;
  logic              waw_hazard;
  logic              hazard;
  logic              leaving;
  logic              accept;

  assign opcode = held.inst[6:0];
  assign rs1_o  = held.inst[15 +: reg_addr_w_p];
  assign rs2_o  = held.inst[20 +: reg_addr_w_p];

  // exu holds the youngest writer, so its result overrides the register file
  assign rs1_fwd = fwd_i.valid && fwd_i.rd == rs1_o;
  assign rs2_fwd = fwd_i.valid && fwd_i.rd == rs2_o;
  assign rs1_val = rs1_fwd ? fwd_i.data : rdata1_i;
  assign rs2_val = rs2_fwd ? fwd_i.data : rdata2_i;

  assign no_read  = opcode == op_lui_p || opcode == op_auipc_p || opcode == op_jal_p;
  assign uses_rs2 = !(opcode == op_imm_p || opcode == op_jalr_p);

  assign raw_hazard = !no_read &&
                      ((busy_i[rs1_o] && !rs1_fwd) ||
                       (uses_rs2 && busy_i[rs2_o] && !rs2_fwd));

  // Only one writer per register may be in flight. Otherwise an older
  // retire would clear the busy bit of a younger pending write.
  assign waw_hazard = req_o.wen && busy_i[req_o.rd];

  assign hazard  = raw_hazard || waw_hazard;
  assign valid_o = valid && !hazard;
  assign leaving = valid_o && ready_i;

  assign fetch_ready_o = !valid || leaving;
  assign accept        = fetch_valid_i && fetch_ready_o;

  assign set_en_o = leaving && req_o.wen;
  assign set_rd_o = req_o.rd;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
    end else if (accept) begin
      valid <= 1'b1;
    end else if (leaving) begin
      valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      held <= fetch_i;
    end
  end

  rv_idu_decoder rv_idu_decoder_inst (
    .inst_i    (held.inst),
    .pc_i      (held.pc),
    .rs1_val_i (rs1_val),
    .rs2_val_i (rs2_val),
    .req_o     (req_o)
  );

endmodule

//--- rv_idu_decoder.sv
`timescale 1ns/1ps

module rv_idu_decoder
  import rv_pkg::*;
(
  input  logic [31:0]       inst_i,
  input  logic [xlen_p-1:0] pc_i,
  input  logic [xlen_p-1:0] rs1_val_i,
  input  logic [xlen_p-1:0] rs2_val_i,
  output exu_req_s          req_o
);

  logic [6:0]              opcode;
  logic [2:0]              funct3;
  logic                    alt;
  logic [reg_addr_w_p-1:0] rd;
  logic [xlen_p-1:0]       imm_i;
  logic [xlen_p-1:0]       imm_u;
  logic [xlen_p-1:0]       imm_j;
  alu_op_e                 f3_op;

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];
  // funct7 bit 5 selects sub and sra
  assign alt    = inst_i[30];
  assign rd     = inst_i[7 +: reg_addr_w_p];

  assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_u = {inst_i[31:12], 12'b0};
  assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  // op-imm has no subtract, so alt only matters there for the shift
  always_comb begin
    case (funct3)
      3'b000:  f3_op = (opcode == op_op_p && alt) ? alu_sub : alu_add;
      3'b001:  f3_op = alu_sll;
      3'b010:  f3_op = alu_slt;
      3'b011:  f3_op = alu_sltu;
      3'b100:  f3_op = alu_xor;
      3'b101:  f3_op = alt ? alu_sra : alu_srl;
      3'b110:  f3_op = alu_or;
      default: f3_op = alu_and;
    endcase
  end

  always_comb begin
    req_o        = '0;
    req_o.pc     = pc_i;
    req_o.rd     = rd;
    req_o.alu_op = alu_add;
    case (opcode)
      op_lui_p: begin
        req_o.op2    = imm_u;
        req_o.alu_op = alu_pass_b;
        req_o.wen    = 1'b1;
      end
      op_auipc_p: begin
        req_o.op1 = pc_i;
        req_o.op2 = imm_u;
        req_o.wen = 1'b1;
      end
      op_jal_p: begin
        req_o.opj = pc_i;
        req_o.op2 = imm_j;
        req_o.wen = 1'b1;
        req_o.jen = 1'b1;
      end
      op_jalr_p: begin
        req_o.opj = rs1_val_i;
        req_o.op2 = imm_i;
        req_o.wen = 1'b1;
        req_o.jen = 1'b1;
      end
      op_op_p: begin
        req_o.op1    = rs1_val_i;
        req_o.op2    = rs2_val_i;
        req_o.alu_op = f3_op;
        req_o.wen    = 1'b1;
      end
      op_imm_p: begin
        req_o.op1    = rs1_val_i;
        req_o.op2    = imm_i;
        req_o.alu_op = f3_op;
        req_o.wen    = 1'b1;
      end
      default: begin
        // unknown opcodes still retire but write nothing
        req_o.wen = 1'b0;
      end
    endcase
    // a write to x0 is dropped here so it never marks the scoreboard
    if (rd == '0) begin
      req_o.wen = 1'b0;
    end
  end

endmodule

//--- rv_pkg.sv
package rv_pkg;

  localparam int xlen_p       = 32;
  localparam int reg_addr_w_p = 4;

  // base opcodes of the rv32e subset handled by the pipeline
  localparam logic [6:0] op_lui_p   = 7'b0110111;
  localparam logic [6:0] op_auipc_p = 7'b0010111;
  localparam logic [6:0] op_jal_p   = 7'b1101111;
  localparam logic [6:0] op_jalr_p  = 7'b1100111;
  localparam logic [6:0] op_op_p    = 7'b0110011;
  localparam logic [6:0] op_imm_p   = 7'b0010011;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  typedef struct packed {
    logic [xlen_p-1:0] pc;
    logic [31:0]       inst;
  } fetch_s;

  // opj is the jump base, op2 carries the jump offset for jal and jalr
  typedef struct packed {
    logic [xlen_p-1:0]       pc;
    logic [xlen_p-1:0]       op1;
    logic [xlen_p-1:0]       op2;
    logic [xlen_p-1:0]       opj;
    alu_op_e                 alu_op;
    logic [reg_addr_w_p-1:0] rd;
    logic                    wen;
    logic                    jen;
  } exu_req_s;

  typedef struct packed {
    logic [xlen_p-1:0]       pc;
    logic [reg_addr_w_p-1:0] rd;
    logic [xlen_p-1:0]       wdata;
    logic                    wen;
    logic                    jen;
    logic [xlen_p-1:0]       target;
  } wb_req_s;

  typedef struct packed {
    logic [xlen_p-1:0]       pc;
    logic [reg_addr_w_p-1:0] rd;
    logic [xlen_p-1:0]       wdata;
    logic                    wen;
    logic                    jen;
    logic [xlen_p-1:0]       target;
  } retire_s;

  typedef struct packed {
    logic                    valid;
    logic [reg_addr_w_p-1:0] rd;
    logic [xlen_p-1:0]       data;
  } fwd_s;

endpackage

//--- rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile
  import rv_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst,
  input  logic [reg_addr_w_p-1:0]       rs1_i,
  input  logic [reg_addr_w_p-1:0]       rs2_i,
  output logic [xlen_p-1:0]             rdata1_o,
  output logic [xlen_p-1:0]             rdata2_o,
  output logic [(1<<reg_addr_w_p)-1:0]  busy_o,
  input  logic                          set_en_i,
  input  logic [reg_addr_w_p-1:0]       set_rd_i,
  input  logic                          wen_i,
  input  logic [reg_addr_w_p-1:0]       wrd_i,
  input  logic [xlen_p-1:0]             wdata_i
);

  logic [xlen_p-1:0]            regs [1:(1<<reg_addr_w_p)-1];
  logic [(1<<reg_addr_w_p)-1:0] busy;

  // x0 has no storage and always reads as zero
  assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];
  assign busy_o   = busy;

  always_ff @(posedge clk) begin
    if (wen_i && wrd_i != '0) begin
      regs[wrd_i] <= wdata_i;
    end
  end

  // the set comes last so a new writer wins over a retiring one
  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= '0;
    end else begin
      if (wen_i) begin
        busy[wrd_i] <= 1'b0;
      end
      if (set_en_i && set_rd_i != '0) begin
        busy[set_rd_i] <= 1'b1;
      end
    end
  end

endmodule

//--- rv_wbu.sv
`timescale 1ns/1ps

module rv_wbu
  import rv_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    valid_i,
  input  wb_req_s                 wb_i,
  output logic                    ready_o,
  output logic                    wen_o,
  output logic [reg_addr_w_p-1:0] wrd_o,
  output logic [xlen_p-1:0]       wdata_o,
  output logic                    retire_valid_o,
  output retire_s                 retire_o,
  input  logic                    retire_ready_i
);

  wb_req_s wb;
  logic    valid;

  assign ready_o = !valid || retire_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
    end else if (ready_o) begin
      valid <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i && ready_o) begin
      wb <= wb_i;
    end
  end

  // the register file is written exactly when the retire transfer happens
  assign wen_o   = valid && retire_ready_i && wb.wen;
  assign wrd_o   = wb.rd;
  assign wdata_o = wb.wdata;

  assign retire_valid_o  = valid;
  assign retire_o.pc     = wb.pc;
  assign retire_o.rd     = wb.rd;
  assign retire_o.wdata  = wb.wdata;
  assign retire_o.wen    = wb.wen;
  assign retire_o.jen    = wb.jen;
  assign retire_o.target = wb.target;

endmodule

//--- tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core
  import rv_pkg::*;
();

  localparam logic [31:0] seed_c       = 32'hc7a1_072a;
  localparam int          num_random_c = 400;
  localparam int          timeout_c    = 200;

  logic        clk;
  logic        rst;
  logic        fetch_valid;
  fetch_s      fetch;
  logic        fetch_ready;
  logic        retire_valid;
  retire_s     retire;
  logic        retire_ready;

  fetch_s      sent_q[$];
  logic [31:0] ref_regs [0:15];
  logic [31:0] rng;
  logic [31:0] ready_rng = ~seed_c;
  logic [31:0] next_pc;
  logic [3:0]  last_rd;
  logic        hold_pending = 1'b0;
  retire_s     held_retire;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  rv_core rv_core_inst (
    .clk            (clk),
    .rst            (rst),
    .fetch_valid_i  (fetch_valid),
    .fetch_i        (fetch),
    .fetch_ready_o  (fetch_ready),
    .retire_valid_o (retire_valid),
    .retire_o       (retire),
    .retire_ready_i (retire_ready)
  );

  task automatic report_mismatch(input string name, input logic [127:0] got,
                                 input logic [127:0] expected);
    $display("FAILED at %0t: %s = %0h, expected %0h", $time, name, got, expected);
    $display("TEST FAILED");
    $fatal(1, "stopped at the first failed check");
  endtask

  task automatic report_failure(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "stopped at the first failed check");
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] draw();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic logic [31:0] r_format(input logic [6:0] f7, input logic [3:0] rs2,
                                           input logic [3:0] rs1, input logic [2:0] f3,
                                           input logic [3:0] rd, input logic [6:0] op);
    return {f7, 1'b0, rs2, 1'b0, rs1, f3, 1'b0, rd, op};
  endfunction

  function automatic logic [31:0] i_format(input logic [11:0] imm, input logic [3:0] rs1,
                                           input logic [2:0] f3, input logic [3:0] rd,
                                           input logic [6:0] op);
    return {imm, 1'b0, rs1, f3, 1'b0, rd, op};
  endfunction

  function automatic logic [31:0] u_format(input logic [19:0] imm, input logic [3:0] rd,
                                           input logic [6:0] op);
    return {imm, 1'b0, rd, op};
  endfunction

  function automatic logic [31:0] j_format(input logic [20:0] imm, input logic [3:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 1'b0, rd, op_jal_p};
  endfunction

  // ALU semantics of the base integer ISA, shared by OP and OP-IMM
  function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic sub,
                                            input logic arith, input logic [31:0] a,
                                            input logic [31:0] b);
    case (f3)
      3'd0: return sub ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: begin
        if (arith) begin
          return $signed(a) >>> b[4:0];
        end
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // sources lean on the last destination so forwarding and stalls happen often
  function automatic logic [31:0] random_inst();
    logic [31:0] r;
    logic [31:0] imm;
    logic [3:0]  rd;
    logic [3:0]  rs1;
    logic [3:0]  rs2;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm12;
    logic [31:0] inst;
    r   = draw();
    imm = draw();
    rd  = r[22] ? last_rd : r[3:0];
    rs1 = r[4] ? last_rd : r[8:5];
    rs2 = r[9] ? last_rd : r[13:10];
    f3  = r[16:14];
    alt = r[21] && (f3 == 3'd0 || f3 == 3'd5);
    case (r[20:17])
      4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5: begin
        inst = r_format({1'b0, alt, 5'b0}, rs2, rs1, f3, rd, op_op_p);
      end
      4'd6, 4'd7, 4'd8, 4'd9, 4'd10: begin
        case (f3)
          3'd1:    imm12 = {7'b0, imm[4:0]};
          3'd5:    imm12 = {1'b0, r[21], 5'b0, imm[4:0]};
          default: imm12 = imm[11:0];
        endcase
        inst = i_format(imm12, rs1, f3, rd, op_imm_p);
      end
      4'd11:   inst = u_format(imm[31:12], rd, op_lui_p);
      4'd12:   inst = u_format(imm[31:12], rd, op_auipc_p);
      4'd13:   inst = j_format({imm[20:1], 1'b0}, rd);
      default: inst = i_format(imm[11:0], rs1, 3'd0, rd, op_jalr_p);
    endcase
    last_rd = rd;
    return inst;
  endfunction

  // called on a falling edge, returns on the falling edge after the transfer
  task automatic send_inst(input logic [31:0] inst);
    int waited;
    waited      = 0;
    fetch_valid = 1'b1;
    fetch.pc    = next_pc;
    fetch.inst  = inst;
    @(posedge clk);
    while (!fetch_ready) begin
      waited++;
      if (waited > timeout_c) begin
        report_failure("fetch_ready_o stayed low for too long");
      end
      @(posedge clk);
    end
    sent_q.push_back(fetch);
    next_pc = next_pc + 32'd4;
    @(negedge clk);
    fetch_valid = 1'b0;
  endtask

  task automatic check_retire();
    fetch_s      exp;
    logic [31:0] inst;
    logic [3:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] wdata;
    logic [31:0] target;
    logic        jump;
    assert (sent_q.size() != 0)
      else report_failure("retire with no instruction outstanding");
    exp    = sent_q.pop_front();
    inst   = exp.inst;
    rd     = inst[10:7];
    a      = ref_regs[inst[18:15]];
    b      = ref_regs[inst[23:20]];
    imm_i  = {{20{inst[31]}}, inst[31:20]};
    imm_u  = {inst[31:12], 12'b0};
    imm_j  = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    jump   = 1'b0;
    target = '0;
    case (inst[6:0])
      op_lui_p:   wdata = imm_u;
      op_auipc_p: wdata = exp.pc + imm_u;
      op_jal_p: begin
        wdata  = exp.pc + 32'd4;
        target = (exp.pc + imm_j) & ~32'd1;
        jump   = 1'b1;
      end
      op_jalr_p: begin
        wdata  = exp.pc + 32'd4;
        target = (a + imm_i) & ~32'd1;
        jump   = 1'b1;
      end
      op_op_p: wdata = alu_model(inst[14:12], inst[30], inst[30], a, b);
      default: wdata = alu_model(inst[14:12], 1'b0, inst[30], a, imm_i);
    endcase
    assert (retire.pc == exp.pc) else report_mismatch("retire_o.pc", retire.pc, exp.pc);
    assert (retire.rd == rd) else report_mismatch("retire_o.rd", retire.rd, rd);
    // x0 is never written, so later reads of it stay zero in the model too
    assert (retire.wen == (rd != 4'd0))
      else report_mismatch("retire_o.wen", retire.wen, rd != 4'd0);
    assert (retire.jen == jump) else report_mismatch("retire_o.jen", retire.jen, jump);
    assert (retire.wdata == wdata)
      else report_mismatch("retire_o.wdata", retire.wdata, wdata);
    if (jump) begin
      assert (retire.target == target)
        else report_mismatch("retire_o.target", retire.target, target);
    end
    if (rd != 4'd0) begin
      ref_regs[rd] = wdata;
    end
  endtask

  always @(negedge clk) begin
    ready_rng    = xorshift32(ready_rng);
    retire_ready = ready_rng[1:0] != 2'd0;
  end

  always @(posedge clk) begin
    if (!rst) begin
      if (hold_pending) begin
        assert (retire_valid)
          else report_failure("retire_valid_o dropped while retire_ready_i was low");
        assert (retire == held_retire)
          else report_mismatch("retire_o", retire, held_retire);
      end
      hold_pending = retire_valid && !retire_ready;
      held_retire  = retire;
      if (retire_valid && retire_ready) begin
        check_retire();
      end
    end
  end

  initial begin
    logic [31:0] imm;
    int          gap;
    int          waited;
    rst          = 1'b1;
    fetch_valid  = 1'b0;
    fetch        = '0;
    retire_ready = 1'b0;
    rng          = seed_c;
    next_pc      = 32'h0000_1000;
    last_rd      = 4'd1;
    for (int idx = 0; idx < 16; idx++) begin
      ref_regs[idx] = '0;
    end
    repeat (4) @(negedge clk);
    rst = 1'b0;
    assert (!retire_valid) else report_mismatch("retire_valid_o", retire_valid, 1'b0);
    assert (fetch_ready) else report_mismatch("fetch_ready_o", fetch_ready, 1'b1);

    // give every register a known value before random traffic reads it
    for (int idx = 1; idx < 16; idx++) begin
      imm = draw();
      send_inst(u_format(imm[31:12], idx[3:0], op_lui_p));
      send_inst(i_format(imm[11:0], idx[3:0], 3'd0, idx[3:0], op_imm_p));
    end

    for (int n = 0; n < num_random_c; n++) begin
      send_inst(random_inst());
      imm = draw();
      gap = (imm[2:0] < 3'd5) ? 0 : int'(imm[4:3]);
      repeat (gap) @(negedge clk);
    end

    waited = 0;
    while (sent_q.size() != 0) begin
      waited++;
      if (waited > timeout_c) begin
        report_failure("pipeline did not drain all instructions");
      end
      @(negedge clk);
    end
    repeat (10) @(negedge clk);
    assert (!retire_valid) else report_failure("retire_valid_o high after the pipeline drained");

    $display("TEST OK");
    $finish;
  end

endmodule
